// File: filelist.f
nora_bus_pkg.sv
nora_board_pkg.sv
via_gpio_regs.sv
heartbeat_blinker.sv
board_pin_mux.sv
nora_gpio_top.sv
tb_nora_gpio.sv

// File: run_sim.sh
#!/bin/sh
# Builds the NORA GPIO testbench with Verilator, runs it and checks the log

rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_nora_gpio -f filelist.f -o sim_nora_gpio \
    && ./obj_dir/sim_nora_gpio | tee sim.log \
    && grep -q "Test passed" sim.log \
    && echo "Simulation result: PASS" \
    || { echo "Simulation result: FAIL"; exit 1; }

// File: tb_nora_gpio.sv
// Testbench for the NORA GPIO top
// Table of bus accesses with expected read bytes and pin levels, then a heartbeat check
`timescale 1ns/1ps

module tb_nora_gpio;

    localparam int CLK_PERIOD = 40;
    localparam int BLINK_BITS = 4;                      // Short heartbeat for simulation
    localparam int OP_RD      = 0;
    localparam int OP_WR      = 1;
    localparam int OP_WRNV    = 2;                      // Write without valid strobe

    localparam nora_bus_pkg::slv_addr_t A_ORB  = nora_bus_pkg::REG_ORB;
    localparam nora_bus_pkg::slv_addr_t A_ORA  = nora_bus_pkg::REG_ORA;
    localparam nora_bus_pkg::slv_addr_t A_DDRB = nora_bus_pkg::REG_DDRB;
    localparam nora_bus_pkg::slv_addr_t A_DDRA = nora_bus_pkg::REG_DDRA;

    // Pin vector {nes_clock, nes_latch, scl, scl_oe, sda_oe, led1, led0}
    typedef struct {
        int                      op;
        nora_bus_pkg::slv_addr_t addr;
        nora_bus_pkg::slv_data_t data;
        bit                      rnd;        // Byte from the LCG
        logic [3:0]              pins_in;    // {nes_data0, nes_data1, scl, sda}
        logic [7:0]              rd_mask;    // 0 means no read check
        logic [7:0]              exp_rd;
        bit                      use_model;  // Expected read from model registers
        logic [6:0]              pin_mask;
        logic [6:0]              exp_pins;
    } entry_t;

    logic clk6x;
    logic rst_n_i;
    logic slv_req_i;
    logic slv_rwn_i;
    logic slv_datawr_valid_i;
    nora_bus_pkg::slv_addr_t slv_addr_i;
    nora_bus_pkg::slv_data_t slv_datawr_i;
    nora_bus_pkg::slv_data_t slv_datard_o;
    logic nes_data0_i;
    logic nes_data1_i;
    logic i2c_scl_i;
    logic i2c_sda_i;
    logic nes_clock_o;
    logic nes_latch_o;
    logic i2c_scl_o;
    logic i2c_scl_oe_o;
    logic i2c_sda_oe_o;
    logic cpu_led0_o;
    logic cpu_led1_o;

    entry_t     entries[$];
    logic [7:0] model_regs [0:15];       // Register values as software wrote them
    logic [31:0] lcg_state = 32'hd2448e0f;
    bit         table_built = 1'b0;
    int         errors = 0;
    int         checks = 0;

    nora_gpio_top #(.blink_div_bits(BLINK_BITS)) uut (
        .clk6x(clk6x), .rst_n_i(rst_n_i),
        .slv_req_i(slv_req_i), .slv_rwn_i(slv_rwn_i), .slv_addr_i(slv_addr_i),
        .slv_datawr_i(slv_datawr_i), .slv_datawr_valid_i(slv_datawr_valid_i),
        .slv_datard_o(slv_datard_o),
        .nes_data0_i(nes_data0_i), .nes_data1_i(nes_data1_i),
        .i2c_scl_i(i2c_scl_i), .i2c_sda_i(i2c_sda_i),
        .nes_clock_o(nes_clock_o), .nes_latch_o(nes_latch_o),
        .i2c_scl_o(i2c_scl_o), .i2c_scl_oe_o(i2c_scl_oe_o), .i2c_sda_oe_o(i2c_sda_oe_o),
        .cpu_led0_o(cpu_led0_o), .cpu_led1_o(cpu_led1_o)
    );

    initial
    begin
        clk6x = 1'b0;
        forever #(CLK_PERIOD / 2) clk6x = ~clk6x;
    end

    function automatic logic [7:0] next_random_byte();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state[23:16];                        // Middle bits spread better
    endfunction

    task automatic add_entry(input int op, input nora_bus_pkg::slv_addr_t addr,
                             input logic [7:0] data, input bit rnd, input logic [3:0] pins_in,
                             input logic [7:0] rd_mask, input logic [7:0] exp_rd,
                             input bit use_model, input logic [6:0] pin_mask,
                             input logic [6:0] exp_pins);
        entry_t e;
        e = '{op, addr, data, rnd, pins_in, rd_mask, exp_rd, use_model, pin_mask, exp_pins};
        entries.push_back(e);
    endtask

    // One bus access, request at one edge, sampled at the next, checked at the negedge
    task automatic apply_entry(input int idx);
        entry_t     e;
        logic [7:0] wdata;
        logic [7:0] exp_rd;
        logic [7:0] rd_mask;
        logic [6:0] pins;
        e       = entries[idx];
        wdata   = e.rnd ? next_random_byte() : e.data;
        exp_rd  = e.use_model ? model_regs[e.addr] : e.exp_rd;
        rd_mask = e.use_model ? 8'hff : e.rd_mask;
        @(posedge clk6x);
        slv_req_i          <= 1'b1;
        slv_rwn_i          <= (e.op == OP_RD);
        slv_addr_i         <= e.addr;
        slv_datawr_i       <= wdata;
        slv_datawr_valid_i <= (e.op == OP_WR);
        {nes_data0_i, nes_data1_i, i2c_scl_i, i2c_sda_i} <= e.pins_in;
        @(posedge clk6x);
        slv_req_i          <= 1'b0;
        slv_rwn_i          <= 1'b1;
        slv_datawr_valid_i <= 1'b0;
        if (e.op == OP_WR && e.addr < 4'd4)
            model_regs[e.addr] = wdata;                 // Only valid writes to mapped offsets
        @(negedge clk6x);
        pins = {nes_clock_o, nes_latch_o, i2c_scl_o, i2c_scl_oe_o, i2c_sda_oe_o,
                cpu_led1_o, cpu_led0_o};
        if (e.op == OP_RD && rd_mask != 8'h00)
        begin
            checks++;
            if ((slv_datard_o & rd_mask) !== (exp_rd & rd_mask))
            begin
                errors++;
                $display("FAIL at %0t: entry %0d offset %0d read 0x%02h, expected 0x%02h",
                         $time, idx, e.addr, slv_datard_o, exp_rd);
            end
        end
        if (e.pin_mask != 7'h00)
        begin
            checks++;
            if ((pins & e.pin_mask) !== (e.exp_pins & e.pin_mask))
            begin
                errors++;
                $display("FAIL at %0t: entry %0d pins %b, expected %b (mask %b)",
                         $time, idx, pins, e.exp_pins, e.pin_mask);
            end
        end
    endtask

    // Half period of LED0 measured between successive toggles
    task automatic check_heartbeat();
        logic prev;
        int   cnt;
        int   edges;
        prev  = cpu_led0_o;
        cnt   = 0;
        edges = 0;
        for (int i = 0; i < 40 && edges < 3; i++)
        begin
            @(negedge clk6x);
            cnt++;
            if (cpu_led0_o !== prev)
            begin
                edges++;
                if (edges > 1)                          // First toggle only aligns
                begin
                    checks++;
                    if (cnt != 2 ** (BLINK_BITS - 1))
                    begin
                        errors++;
                        $display("FAIL at %0t: heartbeat half period %0d cycles, expected %0d",
                                 $time, cnt, 2 ** (BLINK_BITS - 1));
                    end
                end
                cnt  = 0;
                prev = cpu_led0_o;
            end
        end
        if (edges < 3)
        begin
            errors++;
            $display("Heartbeat on cpu_led0_o stopped toggling after %0d toggles", edges);
        end
    endtask

    initial
    begin
        wait (table_built);
        #(CLK_PERIOD * (entries.size() * 4 + 64));
        $display("Timeout: run did not finish within %0d clock periods", entries.size() * 4 + 64);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        rst_n_i            <= 1'b0;
        slv_req_i          <= 1'b0;
        slv_rwn_i          <= 1'b1;
        slv_addr_i         <= '0;
        slv_datawr_i       <= '0;
        slv_datawr_valid_i <= 1'b0;
        nes_data0_i        <= 1'b0;
        nes_data1_i        <= 1'b0;
        i2c_scl_i          <= 1'b0;
        i2c_sda_i          <= 1'b0;
        for (int i = 0; i < 16; i++)
            model_regs[i] = 8'h00;
        // Reset state with LED0 masked while the heartbeat runs
        add_entry(OP_RD, A_DDRA, 8'h00, 1'b0, 4'h0, 8'hff, 8'h00, 1'b0, 7'h7e, 7'b1100010);
        add_entry(OP_RD, A_DDRB, 8'h00, 1'b0, 4'h0, 8'hff, 8'h00, 1'b0, 7'h7e, 7'b1100010);
        add_entry(OP_RD, A_ORA,  8'h00, 1'b0, 4'h0, 8'hff, 8'h30, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, A_ORB,  8'h00, 1'b0, 4'h0, 8'hfe, 8'hc2, 1'b0, 7'h00, 7'h00);
        // Random readback, unmapped offsets, write without valid
        add_entry(OP_WR, A_DDRA, 8'h00, 1'b1, 4'h0, 8'h00, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, A_DDRA, 8'h00, 1'b0, 4'h0, 8'h00, 8'h00, 1'b1, 7'h00, 7'h00);
        add_entry(OP_WR, A_DDRB, 8'h00, 1'b1, 4'h0, 8'h00, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, A_DDRB, 8'h00, 1'b0, 4'h0, 8'h00, 8'h00, 1'b1, 7'h00, 7'h00);
        add_entry(OP_WR, 4'd4,   8'hff, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, 4'd4,   8'h00, 1'b0, 4'h0, 8'hff, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_WR, 4'd15,  8'h5a, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, 4'd15,  8'h00, 1'b0, 4'h0, 8'hff, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, 4'd9,   8'h00, 1'b0, 4'h0, 8'hff, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_WRNV, A_DDRB, 8'h00, 1'b1, 4'h0, 8'h00, 8'h00, 1'b0, 7'h00, 7'h00);
        add_entry(OP_RD, A_DDRB, 8'h00, 1'b0, 4'h0, 8'h00, 8'h00, 1'b1, 7'h00, 7'h00);
        // Port A outputs over DDRA/ORA combinations
        add_entry(OP_WR, A_DDRA, 8'h00, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b1100000);
        add_entry(OP_WR, A_ORA,  8'hff, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b1110000);
        add_entry(OP_WR, A_DDRA, 8'h0f, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b0011000);
        add_entry(OP_WR, A_ORA,  8'h00, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b1101100);
        add_entry(OP_WR, A_ORA,  8'h05, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b1001000);
        add_entry(OP_WR, A_ORA,  8'h0a, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b0111100);
        add_entry(OP_WR, A_DDRA, 8'h03, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b1111100);
        // Port A pin readback
        add_entry(OP_RD, A_ORA,  8'h00, 1'b0, 4'ha, 8'hff, 8'hb2, 1'b0, 7'h7c, 7'b1111100);
        add_entry(OP_WR, A_DDRA, 8'h0c, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h7c, 7'b0110000);
        add_entry(OP_RD, A_ORA,  8'h00, 1'b0, 4'h5, 8'hff, 8'h79, 1'b0, 7'h7c, 7'b0110000);
        // Port B and LEDs
        add_entry(OP_WR, A_DDRB, 8'h03, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h03, 7'b0000000);
        add_entry(OP_WR, A_ORB,  8'h01, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h03, 7'b0000001);
        add_entry(OP_RD, A_ORB,  8'h00, 1'b0, 4'h0, 8'hff, 8'hc1, 1'b0, 7'h03, 7'b0000001);
        add_entry(OP_WR, A_ORB,  8'h02, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h03, 7'b0000010);
        add_entry(OP_RD, A_ORB,  8'h00, 1'b0, 4'h0, 8'hff, 8'hc2, 1'b0, 7'h03, 7'b0000010);
        // ORB bit 1 low, so LED1 high after DDRB clear is the idle level
        add_entry(OP_WR, A_ORB,  8'h01, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h03, 7'b0000001);
        add_entry(OP_WR, A_DDRB, 8'h00, 1'b0, 4'h0, 8'h00, 8'h00, 1'b0, 7'h02, 7'b0000010);
        table_built = 1'b1;
        repeat (3) @(posedge clk6x);
        rst_n_i <= 1'b1;
        for (int i = 0; i < entries.size(); i++)
            apply_entry(i);
        check_heartbeat();                              // DDRB now clear
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Test passed");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: nora_gpio_top.sv
// GPIO top of the NORA controller
// VIA register file, heartbeat and board pin mux on the internal slave bus
`timescale 1ns/1ps

module nora_gpio_top #(
    parameter int blink_div_bits = nora_board_pkg::BLINK_DIV_BITS  // Heartbeat counter width
) (
    input  logic                    clk6x,
    input  logic                    rst_n_i,            // Sync reset, active low
    // Internal slave bus
    input  logic                    slv_req_i,
    input  logic                    slv_rwn_i,          // 1 = read
    input  nora_bus_pkg::slv_addr_t slv_addr_i,
    input  nora_bus_pkg::slv_data_t slv_datawr_i,
    input  logic                    slv_datawr_valid_i,
    output nora_bus_pkg::slv_data_t slv_datard_o,
    // Board pins
    input  logic                    nes_data0_i,
    input  logic                    nes_data1_i,
    input  logic                    i2c_scl_i,
    input  logic                    i2c_sda_i,
    output logic                    nes_clock_o,
    output logic                    nes_latch_o,
    output logic                    i2c_scl_o,
    output logic                    i2c_scl_oe_o,
    output logic                    i2c_sda_oe_o,
    output logic                    cpu_led0_o,
    output logic                    cpu_led1_o
);

    nora_bus_pkg::slv_data_t ora;    // Output regs
    nora_bus_pkg::slv_data_t orb;
    nora_bus_pkg::slv_data_t ddra;   // Direction regs
    nora_bus_pkg::slv_data_t ddrb;
    nora_bus_pkg::slv_data_t ira;    // Pin readback
    nora_bus_pkg::slv_data_t irb;
    logic                    blink_led;

    via_gpio_regs u_regs (
        .clk6x              (clk6x),
        .rst_n_i            (rst_n_i),
        .slv_req_i          (slv_req_i),
        .slv_rwn_i          (slv_rwn_i),
        .slv_datawr_valid_i (slv_datawr_valid_i),
        .slv_addr_i         (slv_addr_i),
        .slv_datawr_i       (slv_datawr_i),
        .slv_datard_o       (slv_datard_o),
        .ira_i              (ira),
        .irb_i              (irb),
        .ora_o              (ora),
        .orb_o              (orb),
        .ddra_o             (ddra),
        .ddrb_o             (ddrb)
    );

    // Alive indicator for LED0
    heartbeat_blinker #(
        .DIV_BITS (blink_div_bits)
    ) u_blink (
        .clk6x       (clk6x),
        .rst_n_i     (rst_n_i),
        .blink_led_o (blink_led)
    );

    board_pin_mux u_pins (
        .ora_i        (ora),
        .orb_i        (orb),
        .ddra_i       (ddra),
        .ddrb_i       (ddrb),
        .blink_led_i  (blink_led),
        .nes_data0_i  (nes_data0_i),
        .nes_data1_i  (nes_data1_i),
        .i2c_scl_i    (i2c_scl_i),
        .i2c_sda_i    (i2c_sda_i),
        .nes_clock_o  (nes_clock_o),
        .nes_latch_o  (nes_latch_o),
        .i2c_scl_o    (i2c_scl_o),
        .i2c_scl_oe_o (i2c_scl_oe_o),
        .i2c_sda_oe_o (i2c_sda_oe_o),
        .cpu_led0_o   (cpu_led0_o),
        .cpu_led1_o   (cpu_led1_o),
        .ira_o        (ira),
        .irb_o        (irb)
    );

endmodule

// File: board_pin_mux.sv
// Board pin mux for the VIA ports
// Drives NES, I2C and LED pins and packs pin states into IRA/IRB
`timescale 1ns/1ps

module board_pin_mux (
    input  nora_bus_pkg::slv_data_t ora_i,
    input  nora_bus_pkg::slv_data_t orb_i,
    input  nora_bus_pkg::slv_data_t ddra_i,      // 1 = output
    input  nora_bus_pkg::slv_data_t ddrb_i,
    input  logic                    blink_led_i, // Heartbeat for LED0
    input  logic                    nes_data0_i,
    input  logic                    nes_data1_i,
    input  logic                    i2c_scl_i,   // SCL line level
    input  logic                    i2c_sda_i,   // SDA line level
    output logic                    nes_clock_o, // Active low
    output logic                    nes_latch_o, // Active low
    output logic                    i2c_scl_o,
    output logic                    i2c_scl_oe_o,
    output logic                    i2c_sda_oe_o, // High pulls SDA low
    output logic                    cpu_led0_o,
    output logic                    cpu_led1_o,
    output nora_bus_pkg::slv_data_t ira_o,
    output nora_bus_pkg::slv_data_t irb_o
);

    nora_board_pkg::porta_word_u ora_w;    // ORA split into pins
    nora_board_pkg::porta_word_u ddra_w;   // DDRA split into pins
    nora_board_pkg::porta_word_u ira_w;    // IRA built from pins

    assign ora_w.raw  = ora_i;
    assign ddra_w.raw = ddra_i;

    // NES pad lines, inactive high when not driven by software
    assign nes_clock_o = ddra_w.fields.nes_clock ? ~ora_w.fields.nes_clock : 1'b1;
    assign nes_latch_o = ddra_w.fields.nes_latch ? ~ora_w.fields.nes_latch : 1'b1;

    // SCL as value plus enable
    assign i2c_scl_o    = ora_w.fields.i2c_scl;
    assign i2c_scl_oe_o = ddra_w.fields.i2c_scl;

    // SDA open drain, only ever drives low
    assign i2c_sda_oe_o = ddra_w.fields.i2c_sda & ~ora_w.fields.i2c_sda;

    // LEDs, heartbeat on LED0 when software leaves it as input
    assign cpu_led0_o = ddrb_i[nora_board_pkg::LED0_BIT] ?
                        orb_i[nora_board_pkg::LED0_BIT] : blink_led_i;
    assign cpu_led1_o = ddrb_i[nora_board_pkg::LED1_BIT] ?
                        orb_i[nora_board_pkg::LED1_BIT] : 1'b1;

    // Port A pin readback
    always_comb
    begin
        ira_w.fields.nes_data0 = nes_data0_i;
        ira_w.fields.nes_data1 = nes_data1_i;
        ira_w.fields.spare1    = 1'b1;           // No pin, reads high
        ira_w.fields.spare0    = 1'b1;
        ira_w.fields.nes_clock = ~nes_clock_o;   // Back to active high
        ira_w.fields.nes_latch = ~nes_latch_o;
        ira_w.fields.i2c_scl   = i2c_scl_i;
        ira_w.fields.i2c_sda   = i2c_sda_i;
    end

    assign ira_o = ira_w.raw;

    // Port B readback, only the two LEDs are real pins
    assign irb_o = {nora_board_pkg::PORTB_IN_HIGH, cpu_led1_o, cpu_led0_o};

endmodule

// File: heartbeat_blinker.sv
// Heartbeat blinker, free running counter whose MSB drives the LED
`timescale 1ns/1ps

module heartbeat_blinker #(
    parameter int DIV_BITS = nora_board_pkg::BLINK_DIV_BITS   // Counter width, 2 or more
) (
    input  logic clk6x,
    input  logic rst_n_i,       // Sync reset, active low
    output logic blink_led_o    // Half period is 2^(DIV_BITS-1) cycles
);

    logic [DIV_BITS-1:0] div_cnt;   // Wraps freely

    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            div_cnt <= '0;          // LED starts low
        end
        else
        begin
            div_cnt <= div_cnt + 1'b1;
        end
    end

    // MSB toggles at each half wrap
    assign blink_led_o = div_cnt[DIV_BITS-1];

endmodule

// File: via_gpio_regs.sv
// GPIO part of the simplified 65C22 VIA
// ORA/ORB and DDRA/DDRB behind the internal slave bus, IRA/IRB read back
`timescale 1ns/1ps

module via_gpio_regs (
    input  logic                    clk6x,
    input  logic                    rst_n_i,             // Sync reset, active low
    // Slave bus
    input  logic                    slv_req_i,           // Access this cycle
    input  logic                    slv_rwn_i,           // 1 = read
    input  logic                    slv_datawr_valid_i,  // Write data valid at this edge
    input  nora_bus_pkg::slv_addr_t slv_addr_i,
    input  nora_bus_pkg::slv_data_t slv_datawr_i,
    output nora_bus_pkg::slv_data_t slv_datard_o,        // Held until next read
    // Pin side
    input  nora_bus_pkg::slv_data_t ira_i,               // Port A pin states
    input  nora_bus_pkg::slv_data_t irb_i,               // Port B pin states
    output nora_bus_pkg::slv_data_t ora_o,
    output nora_bus_pkg::slv_data_t orb_o,
    output nora_bus_pkg::slv_data_t ddra_o,              // 1 = output
    output nora_bus_pkg::slv_data_t ddrb_o
);

    logic                    wr_en;     // Write strobe
    logic                    rd_en;     // Read sample strobe
    nora_bus_pkg::slv_data_t rd_mux;    // Selected read byte

    nora_bus_pkg::slv_data_t ora_q;
    nora_bus_pkg::slv_data_t orb_q;
    nora_bus_pkg::slv_data_t ddra_q;
    nora_bus_pkg::slv_data_t ddrb_q;
    nora_bus_pkg::slv_data_t datard_q;

    // Data is only valid together with the valid strobe
    assign wr_en = slv_req_i & ~slv_rwn_i & slv_datawr_valid_i;
    assign rd_en = slv_req_i & slv_rwn_i;

    // Register writes
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            ora_q  <= '0;
            orb_q  <= '0;
            ddra_q <= '0;     // All pins input after reset
            ddrb_q <= '0;
        end
        else if (wr_en)
        begin
            case (slv_addr_i)
                nora_bus_pkg::REG_ORB:  orb_q  <= slv_datawr_i;
                nora_bus_pkg::REG_ORA:  ora_q  <= slv_datawr_i;
                nora_bus_pkg::REG_DDRB: ddrb_q <= slv_datawr_i;
                nora_bus_pkg::REG_DDRA: ddra_q <= slv_datawr_i;
                default: ;          // Unmapped, dropped
            endcase
        end
    end

    // Read select
    // ORx offsets return the pin states, not the output latch
    always_comb
    begin
        case (slv_addr_i)
            nora_bus_pkg::REG_ORB:  rd_mux = irb_i;
            nora_bus_pkg::REG_ORA:  rd_mux = ira_i;
            nora_bus_pkg::REG_DDRB: rd_mux = ddrb_q;
            nora_bus_pkg::REG_DDRA: rd_mux = ddra_q;
            default:                rd_mux = '0;    // Unmapped reads 0
        endcase
    end

    // Read data register, one edge after the request
    always_ff @(posedge clk6x)
    begin
        if (!rst_n_i)
        begin
            datard_q <= '0;
        end
        else if (rd_en)
        begin
            datard_q <= rd_mux;
        end
    end

    assign slv_datard_o = datard_q;

    // To the pin mux
    assign ora_o  = ora_q;
    assign orb_o  = orb_q;
    assign ddra_o = ddra_q;
    assign ddrb_o = ddrb_q;

endmodule

// File: nora_board_pkg.sv
// Board pin layout of the NORA GPIO ports
// Port A field map, port B LED bits and heartbeat default
package nora_board_pkg;

    // Port A bit fields, MSB first
    typedef struct packed {
        logic nes_data0;   // Bit 7, pad 0 serial data
        logic nes_data1;   // Bit 6, pad 1 serial data
        logic spare1;      // Bit 5, no pin
        logic spare0;      // Bit 4, no pin
        logic nes_clock;   // Bit 3, pad clock, pin active low
        logic nes_latch;   // Bit 2, pad latch, pin active low
        logic i2c_scl;     // Bit 1
        logic i2c_sda;     // Bit 0, open drain
    } porta_fields_t;

    // Same port A word, raw byte for the bus or split into pins
    typedef union packed {
        nora_bus_pkg::slv_data_t raw;
        porta_fields_t           fields;
    } porta_word_u;

    // IRB upper bits, fixed pattern seen by software
    localparam logic [5:0] PORTB_IN_HIGH = 6'b110000;

    // LED positions in ORB and DDRB
    localparam int LED0_BIT = 0;   // Falls back to heartbeat
    localparam int LED1_BIT = 1;   // Idles high

    // Heartbeat counter width
    // 22 bits at 48 MHz gives a blink of a few Hz
    localparam int BLINK_DIV_BITS = 22;

endpackage

// File: nora_bus_pkg.sv
// Internal slave bus of the NORA controller
// Address and data widths, register offsets of the simplified VIA
package nora_bus_pkg;

    // Slave address width, VIA decodes the low nibble only
    localparam int SLV_ADDR_W = 4;

    typedef logic [SLV_ADDR_W-1:0] slv_addr_t;   // Register offset
    typedef logic [7:0]            slv_data_t;   // One data byte

    // VIA register map, low four offsets only
    localparam slv_addr_t REG_ORB  = 4'd0;        // ORB on write, IRB on read
    localparam slv_addr_t REG_ORA  = 4'd1;        // ORA on write, IRA on read
    localparam slv_addr_t REG_DDRB = 4'd2;        // Port B direction, 1 = output
    localparam slv_addr_t REG_DDRA = 4'd3;        // Port A direction, 1 = output

    // Offsets 4..15 are unmapped
    // Reads give 0, writes are dropped

endpackage
